/* rtl/div_counter.sv */
// divider iteration counter
module div_counter (
    input logic    clk,
    input logic    rst_n,
    div_if.counter ports
);
    import md_op_pkg::*;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ports.count <= '0;
        else if (ports.start_ack)
            ports.count <= '0; // fresh run
        else if (ports.running)
            ports.count <= ports.count + 1'b1;
    end

    // high during the last of DIV_STEPS run cycles
    assign ports.last = ports.running && (ports.count == DIV_CNT_W'(DIV_STEPS - 1));

endmodule

/* rtl/div_datapath.sv */
// restoring divider datapath
// with sign fix-up and divide-by-zero handling
module div_datapath (
    input logic     clk,
    input logic     rst_n,
    div_if.datapath ports
);
    import md_data_pkg::*;

    logic [WORD_W-1:0] rem_q;     // partial remainder
    logic [WORD_W-1:0] quo_q;     // dividend bits out, quotient bits in
    logic [WORD_W-1:0] dvs_q;     // divisor magnitude
    logic              neg_quo_q;
    logic              neg_rem_q;
    logic              dvs_zero_q;

    logic [WORD_W-1:0] dvd_abs;
    logic [WORD_W-1:0] dvs_abs;
    logic [WORD_W:0]   shifted;
    logic [WORD_W:0]   diff;
    logic              fits;
    logic [WORD_W-1:0] quo_fix;
    logic [WORD_W-1:0] rem_fix;

    // magnitudes, 0x80000000 stays as an unsigned value
    assign dvd_abs = (ports.is_signed && ports.dividend[WORD_W-1]) ?
                     -ports.dividend : ports.dividend;
    assign dvs_abs = (ports.is_signed && ports.divisor[WORD_W-1]) ?
                     -ports.divisor : ports.divisor;

    // one trial subtraction per run cycle
    assign shifted = {rem_q, quo_q[WORD_W-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign fits    = (shifted >= {1'b0, dvs_q});

    always_ff @(posedge clk)
    begin
        if (ports.start_ack)
        begin
            rem_q <= '0;
            quo_q <= dvd_abs;
            dvs_q <= dvs_abs;
        end
        else if (ports.running)
        begin
            rem_q <= fits ? diff[WORD_W-1:0] : shifted[WORD_W-1:0];
            quo_q <= {quo_q[WORD_W-2:0], fits};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            neg_quo_q  <= 1'b0;
            neg_rem_q  <= 1'b0;
            dvs_zero_q <= 1'b0;
        end
        else if (ports.start_ack)
        begin
            neg_quo_q  <= ports.is_signed &
                          (ports.dividend[WORD_W-1] ^ ports.divisor[WORD_W-1]);
            neg_rem_q  <= ports.is_signed & ports.dividend[WORD_W-1]; // follows dividend
            dvs_zero_q <= (ports.divisor == '0);
        end
    end

    // zero divisor leaves the dividend magnitude in rem_q,
    // so the remainder fix-up already returns the dividend
    assign quo_fix = dvs_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    assign ports.quotient  = ports.done ? quo_fix : '0;
    assign ports.remainder = ports.done ? rem_fix : '0;

endmodule

/* rtl/div_fsm.sv */
// divider sequencer
module div_fsm (
    input logic clk,
    input logic rst_n,
    div_if.fsm  ports
);
    import md_op_pkg::*;

    div_state_e state;
    div_state_e state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            DIV_IDLE:
            begin
                if (ports.start)
                    state_next = DIV_RUN;
            end
            DIV_RUN:
            begin
                if (ports.last)
                    state_next = DIV_DONE; // leave after final step
            end
            DIV_DONE:
            begin
                state_next = DIV_IDLE;
            end
            default:
            begin
                state_next = DIV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= DIV_IDLE;
        else
            state <= state_next;
    end

    // start only accepted from idle
    assign ports.start_ack = ports.start && (state == DIV_IDLE);
    assign ports.running   = (state == DIV_RUN);
    assign ports.done      = (state == DIV_DONE); // single cycle by construction

endmodule

/* rtl/div_if.sv */
// divider control and data bundle
interface div_if;
    import md_op_pkg::*;
    import md_data_pkg::*;

    logic                 start;      // one-cycle request from top
    logic                 start_ack;  // start seen while idle
    logic                 running;
    logic                 done;       // results valid this cycle
    logic [DIV_CNT_W-1:0] count;
    logic                 last;       // final run cycle
    logic                 is_signed;
    logic [WORD_W-1:0]    dividend;
    logic [WORD_W-1:0]    divisor;
    logic [WORD_W-1:0]    quotient;
    logic [WORD_W-1:0]    remainder;

    modport fsm (
        input  start, last,
        output start_ack, running, done
    );

    modport counter (
        input  start_ack, running,
        output count, last
    );

    modport datapath (
        input  start_ack, running, done, is_signed, dividend, divisor,
        output quotient, remainder
    );

endinterface

/* rtl/hilo_regs.sv */
// HI/LO register pair
module hilo_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  md_data_pkg::hilo_wen_t         wen,
    input  md_data_pkg::hilo_t             wdata,
    input  logic                           sel_hi,
    output logic [md_data_pkg::WORD_W-1:0] rdata
);
    import md_data_pkg::*;

    logic [WORD_W-1:0] hi_q;
    logic [WORD_W-1:0] lo_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else
        begin
            if (wen.hi)
                hi_q <= wdata.hi;
            if (wen.lo)
                lo_q <= wdata.lo; // halves independent
        end
    end

    assign rdata = sel_hi ? hi_q : lo_q;

endmodule

/* rtl/md_data_pkg.sv */
// multiply-divide data shapes
package md_data_pkg;

    localparam int WORD_W = 32;

    // HI/LO pair, hi in the upper half
    typedef struct packed {
        logic [WORD_W-1:0] hi;
        logic [WORD_W-1:0] lo;
    } hilo_t;

    // per-half write enables
    typedef struct packed {
        logic hi;
        logic lo;
    } hilo_wen_t;

endpackage

/* rtl/md_op_pkg.sv */
// multiply-divide operation codes
// and divider sequencing constants
package md_op_pkg;

    // operation presented by the issuing pipeline
    typedef enum logic [2:0] {
        MD_NONE  = 3'd0,
        MD_MULT  = 3'd1,
        MD_MULTU = 3'd2,
        MD_DIV   = 3'd3,
        MD_DIVU  = 3'd4,
        MD_MTHI  = 3'd5,
        MD_MTLO  = 3'd6
    } md_op_e;

    // divider sequencer states
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

    localparam int DIV_STEPS = 32; // one quotient bit per run cycle
    localparam int DIV_CNT_W = 6;

endpackage

/* rtl/mult_div.sv */
// multiply-divide unit top
// HI/LO results for a 32-bit MIPS-style core
module mult_div (
    input  logic                           clk,
    input  logic                           rst_n,
    input  md_op_pkg::md_op_e              op,
    input  logic [md_data_pkg::WORD_W-1:0] in0,
    input  logic [md_data_pkg::WORD_W-1:0] in1,
    input  logic                           sel_hi,
    output logic [md_data_pkg::WORD_W-1:0] result,
    output logic                           ready
);
    import md_op_pkg::*;
    import md_data_pkg::*;

    div_if div_bus ();

    logic      mul_issue;
    logic      mul_signed;
    logic      mul_valid;
    hilo_t     mul_product;
    hilo_t     mv_data;   // move stage value
    hilo_wen_t mv_wen;
    hilo_t     wr_data;
    hilo_wen_t wr_wen;

    // ready low from start acceptance until the done write
    assign ready = !(div_bus.running || div_bus.done);

    // decode, nothing issues while ready is low
    assign mul_issue  = ready && ((op == MD_MULT) || (op == MD_MULTU));
    assign mul_signed = (op == MD_MULT);

    assign div_bus.start     = ready && ((op == MD_DIV) || (op == MD_DIVU));
    assign div_bus.is_signed = (op == MD_DIV);
    assign div_bus.dividend  = in0;
    assign div_bus.divisor   = in1;

    mult_pipe u_mult_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mul_issue),
        .is_signed (mul_signed),
        .a         (in0),
        .b         (in1),
        .out_valid (mul_valid),
        .product   (mul_product)
    );

    div_fsm u_div_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .ports (div_bus.fsm)
    );

    div_counter u_div_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .ports (div_bus.counter)
    );

    div_datapath u_div_datapath (
        .clk   (clk),
        .rst_n (rst_n),
        .ports (div_bus.datapath)
    );

    // mthi/mtlo take in0 for either half
    always_ff @(posedge clk)
    begin
        mv_data.hi <= in0;
        mv_data.lo <= in0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mv_wen <= '0;
        else
        begin
            mv_wen.hi <= ready && (op == MD_MTHI);
            mv_wen.lo <= ready && (op == MD_MTLO);
        end
    end

    // write sources never coincide, divider first anyway
    always_comb
    begin
        if (div_bus.done)
        begin
            wr_wen  = '{hi: 1'b1, lo: 1'b1};
            wr_data = '{hi: div_bus.remainder, lo: div_bus.quotient};
        end
        else if (mul_valid)
        begin
            wr_wen  = '{hi: 1'b1, lo: 1'b1};
            wr_data = mul_product;
        end
        else
        begin
            wr_wen  = mv_wen;
            wr_data = mv_data;
        end
    end

    hilo_regs u_hilo_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (wr_wen),
        .wdata  (wr_data),
        .sel_hi (sel_hi),
        .rdata  (result)
    );

endmodule

/* rtl/mult_pipe.sv */
// two-stage 32x32 multiplier
module mult_pipe (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic                          is_signed,
    input  logic [md_data_pkg::WORD_W-1:0] a,
    input  logic [md_data_pkg::WORD_W-1:0] b,
    output logic                          out_valid,
    output md_data_pkg::hilo_t            product
);
    import md_data_pkg::*;

    logic signed [WORD_W:0]     a_q;     // 33 bits, sign or zero extended
    logic signed [WORD_W:0]     b_q;
    logic                       valid_q;
    logic signed [2*WORD_W+1:0] full;

    // stage one, operand capture
    always_ff @(posedge clk)
    begin
        a_q <= {is_signed & a[WORD_W-1], a};
        b_q <= {is_signed & b[WORD_W-1], b};
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid_q   <= in_valid;
            out_valid <= valid_q; // second stage follows first
        end
    end

    // 33x33 signed covers both signed and unsigned forms
    assign full = a_q * b_q;

    // stage two, product capture
    always_ff @(posedge clk)
    begin
        product <= full[2*WORD_W-1:0];
    end

endmodule

/* src.f */
+incdir+verification
rtl/md_op_pkg.sv
rtl/md_data_pkg.sv
rtl/div_if.sv
rtl/mult_pipe.sv
rtl/div_fsm.sv
rtl/div_counter.sv
rtl/div_datapath.sv
rtl/hilo_regs.sv
rtl/mult_div.sv
verification/tb_mult_div.sv

/* verification/tb_md_checks.svh */
// compare and wait helpers
`ifndef TB_MD_CHECKS_SVH
`define TB_MD_CHECKS_SVH

task automatic check_word(
    input string             name,
    input logic [WORD_W-1:0] got,
    input logic [WORD_W-1:0] exp
);
    checks_run++;
    if (got !== exp)
    begin
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        fail_run();
    end
endtask

task automatic check_ready(input logic got, input logic exp);
    checks_run++;
    if (got !== exp)
    begin
        $display("ERR ready got 0x%h expected 0x%h", got, exp);
        fail_run();
    end
endtask

// both halves through the read select
task automatic check_hilo(input hilo_t exp);
    sel_hi = 1'b1;
    #1;
    check_word("result(hi)", result, exp.hi);
    sel_hi = 1'b0;
    #1;
    check_word("result(lo)", result, exp.lo);
endtask

// n rising edges, landing just past the drive point
task automatic step_cycles(input int n);
    repeat (n)
    begin
        @(posedge clk);
        #DRIVE_DLY;
    end
endtask

task automatic wait_ready();
    int waited;

    waited = 0;
    while (!ready && waited < READY_TIMEOUT)
    begin
        step_cycles(1);
        waited++;
    end
    if (!ready)
    begin
        $display("timed out after %0d cycles waiting for ready to rise", waited);
        fail_run();
    end
endtask

`endif

/* verification/tb_mult_div.sv */
// multiply-divide unit testbench
module tb_mult_div;
    import md_op_pkg::*;
    import md_data_pkg::*;

    localparam int DRIVE_DLY     = 10;
    localparam int READY_TIMEOUT = 100; // division takes about 34 cycles

    logic              clk;
    logic              rst_n;
    md_op_e            op;
    logic [WORD_W-1:0] in0;
    logic [WORD_W-1:0] in1;
    logic              sel_hi;
    logic [WORD_W-1:0] result;
    logic              ready;

    logic [15:0] lfsr_q;
    hilo_t       model;      // expected HI/LO contents
    int          checks_run;

    mult_div u_mult_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (op),
        .in0    (in0),
        .in1    (in1),
        .sel_hi (sel_hi),
        .result (result),
        .ready  (ready)
    );

    initial
        clk = 1'b0;

    always #50 clk = ~clk;

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    `include "tb_md_checks.svh"

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_word(output logic [WORD_W-1:0] w);
        w = '0;
        for (int i = 0; i < WORD_W; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q); // one step per bit
            w      = {w[WORD_W-2:0], lfsr_q[0]};
        end
    endtask

    // full 64-bit product of the extended operands
    function automatic hilo_t model_mult(input logic sgn, input logic [WORD_W-1:0] a,
                                         input logic [WORD_W-1:0] b);
        logic [2*WORD_W-1:0] xa;
        logic [2*WORD_W-1:0] xb;

        xa = sgn ? {{WORD_W{a[WORD_W-1]}}, a} : {{WORD_W{1'b0}}, a};
        xb = sgn ? {{WORD_W{b[WORD_W-1]}}, b} : {{WORD_W{1'b0}}, b};
        return xa * xb;
    endfunction

    // hi gets the remainder, lo the quotient
    function automatic hilo_t model_div(input logic sgn, input logic [WORD_W-1:0] a,
                                        input logic [WORD_W-1:0] b);
        logic signed [WORD_W-1:0] sa;
        logic signed [WORD_W-1:0] sb;
        hilo_t                    r;

        if (b == '0)
        begin
            r.lo = '1;
            r.hi = a;
        end
        else if (sgn && a == 32'h8000_0000 && b == '1)
        begin
            r.lo = 32'h8000_0000; // overflow case
            r.hi = '0;
        end
        else if (sgn)
        begin
            sa   = a;
            sb   = b;
            r.lo = sa / sb; // truncates toward zero
            r.hi = sa % sb;
        end
        else
        begin
            r.lo = a / b;
            r.hi = a % b;
        end
        return r;
    endfunction

    // present one op for a single edge
    task automatic issue_op(input md_op_e o, input logic [WORD_W-1:0] a,
                            input logic [WORD_W-1:0] b);
        op  = o;
        in0 = a;
        in1 = b;
        step_cycles(1);
        op  = MD_NONE;
    endtask

    task automatic mult_one(input logic sgn, input logic [WORD_W-1:0] a,
                            input logic [WORD_W-1:0] b);
        issue_op(sgn ? MD_MULT : MD_MULTU, a, b);
        step_cycles(2);
        model = model_mult(sgn, a, b);
        check_hilo(model);
    endtask

    task automatic div_one(input logic sgn, input logic [WORD_W-1:0] a,
                           input logic [WORD_W-1:0] b);
        check_ready(ready, 1'b1);
        issue_op(sgn ? MD_DIV : MD_DIVU, a, b);
        check_ready(ready, 1'b0);
        wait_ready();
        model = model_div(sgn, a, b);
        check_hilo(model);
    endtask

    task automatic reset_and_moves();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] junk;

        model = '0;
        check_ready(ready, 1'b1);
        check_hilo(model);
        draw_word(a);
        draw_word(junk);
        issue_op(MD_MTHI, a, junk);
        step_cycles(1);
        model.hi = a;
        check_hilo(model);
        draw_word(a);
        issue_op(MD_MTLO, a, junk);
        step_cycles(1);
        model.lo = a;
        check_hilo(model);
    endtask

    task automatic mult_products();
        logic [WORD_W-1:0] corners [4];
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] a2;
        logic [WORD_W-1:0] b2;

        corners = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0001, 32'h7FFF_FFFF};
        for (int s = 0; s < 2; s++)
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    mult_one(s[0], corners[i], corners[j]);
        for (int i = 0; i < 8; i++)
        begin
            draw_word(a);
            draw_word(b);
            mult_one(i[0], a, b);
        end
        // back to back, two in flight
        draw_word(a);
        draw_word(b);
        draw_word(a2);
        draw_word(b2);
        issue_op(MD_MULT, a, b);
        issue_op(MD_MULTU, a2, b2);
        step_cycles(1);
        check_hilo(model_mult(1'b1, a, b));
        step_cycles(1);
        model = model_mult(1'b0, a2, b2);
        check_hilo(model);
    endtask

    task automatic div_random();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] mag;
        logic [WORD_W-1:0] k;

        for (int i = 0; i < 8; i++)
            for (int s = 0; s < 2; s++)
            begin
                draw_word(a);
                draw_word(mag);
                draw_word(k);
                mag = mag >> k[4:0]; // spread quotient sizes
                if (s == 1)
                begin
                    a = {i[0], a[WORD_W-2:0]};
                    mag = i[1] ? -mag : mag;
                end
                div_one(s[0], a, mag);
            end
    endtask

    task automatic div_corners();
        div_one(1'b1, 32'hDEAD_BEEF, 32'h0);
        div_one(1'b0, 32'hDEAD_BEEF, 32'h0);
        div_one(1'b1, 32'h0000_1234, 32'h0);
        div_one(1'b1, 32'h8000_0000, 32'hFFFF_FFFF);
        div_one(1'b0, 32'h8000_0000, 32'hFFFF_FFFF);
        div_one(1'b0, 32'h0000_0003, 32'h0000_0010);
        div_one(1'b1, 32'hFFFF_FFFD, 32'h0000_0010); // -3 / 16
        div_one(1'b1, 32'h0000_0007, 32'hFFFF_FFFE);
    endtask

    task automatic busy_ignores_ops();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] x;

        draw_word(a);
        draw_word(b);
        draw_word(x);
        issue_op(MD_DIVU, a, b);
        check_ready(ready, 1'b0);
        issue_op(MD_MULT, x, x);
        check_ready(ready, 1'b0);
        issue_op(MD_MTLO, x, x);
        issue_op(MD_DIV, x, 32'h3);
        step_cycles(2);
        check_ready(ready, 1'b0);
        check_hilo(model); // earlier contents kept while busy
        wait_ready();
        model = model_div(1'b0, a, b);
        check_hilo(model);
        step_cycles(3); // nothing late may land
        check_ready(ready, 1'b1);
        check_hilo(model);
    endtask

    initial
    begin
        rst_n      = 1'b0;
        op         = MD_NONE;
        in0        = '0;
        in1        = '0;
        sel_hi     = 1'b0;
        lfsr_q     = 16'd55362;
        checks_run = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        reset_and_moves();
        mult_products();
        div_random();
        div_corners();
        busy_ignores_ops();

        if (checks_run > 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("no checks were run");
            fail_run();
        end
    end

endmodule
